//--- nes_io_pkg.sv
// shared types and constants for the console io glue
// widths, uart register map, clock-enable phases, autofire timing

`default_nettype none

package nes_io_pkg;

  // data and address widths
  typedef logic [7:0]  byte_t;       // uart, loader and memory data
  typedef logic [7:0]  uart_addr_t;  // uart register address
  typedef logic [21:0] mem_addr_t;   // 4 MB memory space

  // console buttons, 1 = pressed
  // bit 7..0 : right left down up start select b a
  typedef logic [7:0]  nes_btn_t;

  typedef logic [2:0]  phase_t;      // clock-enable phase

  // uart register map
  localparam uart_addr_t UART_ADDR_CONF = 8'h35;  // loader config, bit 0 holds loader in reset
  localparam uart_addr_t UART_ADDR_ROM  = 8'h37;  // rom byte stream
  localparam uart_addr_t UART_ADDR_BTN1 = 8'h40;  // player 1 host buttons
  localparam uart_addr_t UART_ADDR_BTN2 = 8'h41;  // player 2 host buttons

  // five-phase sequence 0..4
  localparam phase_t CE_LAST      = 3'd4;
  localparam phase_t CE_MEM_PHASE = 3'd0;  // memory controller slot
  localparam phase_t CE_NES_PHASE = 3'd4;  // console core slot

  // autofire half period in clock cycles
  localparam int AUTOFIRE_HALF  = 16;
  localparam int AUTOFIRE_CNT_W = $clog2(AUTOFIRE_HALF);

endpackage

`default_nettype wire

//--- host_if.sv
// host register bus
// loader stream, loader reset and host button bytes from the uart decoder

`timescale 1ns/100ps
`default_nettype none

interface host_if;

  nes_io_pkg::byte_t    loader_data;    // rom byte from uart
  logic                 loader_strobe;  // one cycle per rom byte
  logic                 loader_reset;
  nes_io_pkg::nes_btn_t host_btn1;      // player 1 buttons from host
  nes_io_pkg::nes_btn_t host_btn2;      // player 2 buttons from host

  modport decoder (
    output loader_data,
    output loader_strobe,
    output loader_reset,
    output host_btn1,
    output host_btn2
  );

  modport consumer (
    input loader_data,
    input loader_strobe,
    input loader_reset,
    input host_btn1,
    input host_btn2
  );

endinterface

`default_nettype wire

//--- uart_reg_decoder.sv
// uart register write decoder
// loader config, rom stream forwarding and host button registers

`timescale 1ns/100ps
`default_nettype none

module uart_reg_decoder (
  input  logic                   clk,
  input  logic                   sys_resetn,
  input  nes_io_pkg::byte_t      uart_data,
  input  nes_io_pkg::uart_addr_t uart_addr,
  input  logic                   uart_write,
  host_if.decoder                host
);

  logic                 conf_reset_q;  // config bit 0, only bit in use
  nes_io_pkg::nes_btn_t btn1_q;
  nes_io_pkg::nes_btn_t btn2_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_reset_q <= 1'b0;
      btn1_q       <= '0;
      btn2_q       <= '0;
    end else if (uart_write) begin
      if (uart_addr == nes_io_pkg::UART_ADDR_CONF)
        conf_reset_q <= uart_data[0];
      if (uart_addr == nes_io_pkg::UART_ADDR_BTN1)
        btn1_q <= uart_data;
      if (uart_addr == nes_io_pkg::UART_ADDR_BTN2)
        btn2_q <= uart_data;
    end
  end

  // rom bytes pass straight through to the loader
  assign host.loader_data   = uart_data;
  assign host.loader_strobe = uart_write && (uart_addr == nes_io_pkg::UART_ADDR_ROM);

  // loader held in reset by system reset or host request
  assign host.loader_reset = !sys_resetn || conf_reset_q;

  assign host.host_btn1 = btn1_q;
  assign host.host_btn2 = btn2_q;

endmodule

`default_nettype wire

//--- ce_sequencer.sv
// five-phase clock-enable sequencer
// memory slot in phase 0, console core slot in phase 4
//
// phase    0       1       2       3       4       0
// memory  run_mem  act    rd/wr           dout   run_mem
// core                                   run_nes

`timescale 1ns/100ps
`default_nettype none

module ce_sequencer (
  input  logic clk,
  input  logic sys_resetn,
  input  logic loader_done,
  output logic run_mem,
  output logic run_nes,
  output logic reset_nes
);

  nes_io_pkg::phase_t phase_q;

  // free running, core held off until the rom is in memory
  always_ff @(posedge clk) begin
    if (!sys_resetn)
      phase_q <= '0;
    else if (phase_q == nes_io_pkg::CE_LAST)
      phase_q <= '0;
    else
      phase_q <= phase_q + 3'd1;
  end

  assign reset_nes = !loader_done;

  assign run_mem = loader_done && (phase_q == nes_io_pkg::CE_MEM_PHASE);
  assign run_nes = loader_done && (phase_q == nes_io_pkg::CE_NES_PHASE);  // 4 cycles after run_mem

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// memory request arbiter
// loader writes override console accesses, refresh fills idle memory slots

`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  // control and console side
  input  logic                  run_mem,
  input  logic                  cpu_read,
  input  logic                  ppu_read,
  input  logic                  core_write,
  input  nes_io_pkg::mem_addr_t core_addr,
  input  nes_io_pkg::byte_t     core_wdata,
  // loader side
  input  logic                  loader_write,
  input  logic                  loader_refresh,
  input  nes_io_pkg::mem_addr_t loader_addr,
  input  nes_io_pkg::byte_t     loader_wdata,
  // memory side
  output logic                  mem_read_a,
  output logic                  mem_read_b,
  output logic                  mem_write,
  output logic                  mem_refresh,
  output nes_io_pkg::mem_addr_t mem_addr,
  output nes_io_pkg::byte_t     mem_wdata
);

  logic core_busy;  // any console request this cycle
  logic idle_slot;
  logic loader_ref;

  assign core_busy = cpu_read || ppu_read || core_write;

  // console only gets the memory in its own slot
  assign mem_read_a = cpu_read && run_mem;
  assign mem_read_b = ppu_read && run_mem;
  assign mem_write  = (core_write && run_mem) || loader_write;

  assign idle_slot  = run_mem && !core_busy && !loader_write;
  assign loader_ref = loader_refresh && !loader_write;  // loader idle between bytes
  assign mem_refresh = idle_slot || loader_ref;

  // loader owns address and data while writing
  assign mem_addr  = loader_write ? loader_addr : core_addr;
  assign mem_wdata = loader_write ? loader_wdata : core_wdata;

endmodule

`default_nettype wire

//--- autofire.sv
// autofire for one held button
// square wave, AUTOFIRE_HALF cycles high then AUTOFIRE_HALF low

`timescale 1ns/100ps
`default_nettype none

module autofire (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic fire
);

  logic [nes_io_pkg::AUTOFIRE_CNT_W-1:0] cnt_q;
  logic                                  off_q;  // low half of the wave

  always_ff @(posedge clk) begin
    if (!sys_resetn || !btn) begin
      cnt_q <= '0;  // restart on every press
      off_q <= 1'b0;
    end else if (cnt_q == nes_io_pkg::AUTOFIRE_CNT_W'(nes_io_pkg::AUTOFIRE_HALF - 1)) begin
      cnt_q <= '0;
      off_q <= !off_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // first half fires right on press, drops with release
  assign fire = btn && !off_q;

endmodule

`default_nettype wire

//--- pad_mapper.sv
// gamepad to console button mapping
// dual-shock byte pair in, console button byte out
// square and triangle add autofire on b and a

`timescale 1ns/100ps
`default_nettype none

module pad_mapper (
  input  logic                 clk,
  input  logic                 sys_resetn,
  input  nes_io_pkg::byte_t    rx_dir,   // active low: left down right up start r3 l3 select
  input  nes_io_pkg::byte_t    rx_face,  // active low: square x circle triangle r1 l1 r2 l2
  output nes_io_pkg::nes_btn_t pad_btn
);

  logic square_fire;
  logic triangle_fire;

  autofire af_square (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (!rx_face[7]),
    .fire       (square_fire)
  );

  autofire af_triangle (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (!rx_face[4]),
    .fire       (triangle_fire)
  );

  // x is b, circle is a
  assign pad_btn = {
    !rx_dir[5],                   // right
    !rx_dir[7],                   // left
    !rx_dir[6],                   // down
    !rx_dir[4],                   // up
    !rx_dir[3],                   // start
    !rx_dir[0],                   // select
    !rx_face[6] || square_fire,   // b
    !rx_face[5] || triangle_fire  // a
  };

endmodule

`default_nettype wire

//--- joypad_shifter.sv
// serial joypad port for one player
// strobe latches the buttons, falling pad clock shifts them out lsb first

`timescale 1ns/100ps
`default_nettype none

module joypad_shifter (
  input  logic                 clk,
  input  logic                 sys_resetn,
  input  logic                 strobe,
  input  logic                 pad_clk,
  input  nes_io_pkg::nes_btn_t host_btn,
  input  nes_io_pkg::nes_btn_t pad_btn,
  output logic                 serial_out
);

  nes_io_pkg::nes_btn_t latch_q;
  logic                 pad_clk_q;  // last cycle's pad clock

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      latch_q   <= '0;
      pad_clk_q <= 1'b0;
    end else begin
      pad_clk_q <= pad_clk;
      if (pad_clk_q && !pad_clk)
        latch_q <= {1'b0, latch_q[7:1]};  // zeros after eight reads
      else if (strobe)
        latch_q <= host_btn | pad_btn;
    end
  end

  assign serial_out = latch_q[0];

endmodule

`default_nettype wire

//--- nes_io_top.sv
// console io glue top level
// uart register port, clock-enable sequencer, memory arbiter,
// two gamepad mappers and two serial joypad ports

`timescale 1ns/100ps
`default_nettype none

module nes_io_top (
  // clock, reset and uart
  input  logic                   clk,
  input  logic                   sys_resetn,
  input  nes_io_pkg::byte_t      uart_data,
  input  nes_io_pkg::uart_addr_t uart_addr,
  input  logic                   uart_write,
  // loader
  input  logic                   loader_done,
  input  logic                   loader_write,
  input  logic                   loader_refresh,
  input  nes_io_pkg::mem_addr_t  loader_addr,
  input  nes_io_pkg::byte_t      loader_wdata,
  // console
  input  logic                   cpu_read,
  input  logic                   ppu_read,
  input  logic                   core_write,
  input  nes_io_pkg::mem_addr_t  core_addr,
  input  nes_io_pkg::byte_t      core_wdata,
  input  logic                   joypad_strobe,
  input  logic [1:0]             joypad_clk,
  // gamepads, active low
  input  nes_io_pkg::byte_t      pad1_dir,
  input  nes_io_pkg::byte_t      pad1_face,
  input  nes_io_pkg::byte_t      pad2_dir,
  input  nes_io_pkg::byte_t      pad2_face,
  // outputs
  output nes_io_pkg::byte_t      loader_byte,
  output logic                   loader_byte_valid,
  output logic                   loader_reset,
  output logic                   run_nes,
  output logic                   reset_nes,
  output logic                   mem_read_a,
  output logic                   mem_read_b,
  output logic                   mem_write,
  output logic                   mem_refresh,
  output nes_io_pkg::mem_addr_t  mem_addr,
  output nes_io_pkg::byte_t      mem_wdata,
  output logic [1:0]             joypad_data
);

  host_if host_bus ();

  logic                 run_mem;
  nes_io_pkg::nes_btn_t pad1_btn;
  nes_io_pkg::nes_btn_t pad2_btn;

  uart_reg_decoder uart_reg_decoder_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .uart_data  (uart_data),
    .uart_addr  (uart_addr),
    .uart_write (uart_write),
    .host       (host_bus.decoder)
  );

  // loader stream goes off chip
  assign loader_byte       = host_bus.loader_data;
  assign loader_byte_valid = host_bus.loader_strobe;
  assign loader_reset      = host_bus.loader_reset;

  ce_sequencer ce_sequencer_inst (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .loader_done (loader_done),
    .run_mem     (run_mem),
    .run_nes     (run_nes),
    .reset_nes   (reset_nes)
  );

  mem_arbiter mem_arbiter_inst (
    .run_mem        (run_mem),
    .cpu_read       (cpu_read),
    .ppu_read       (ppu_read),
    .core_write     (core_write),
    .core_addr      (core_addr),
    .core_wdata     (core_wdata),
    .loader_write   (loader_write),
    .loader_refresh (loader_refresh),
    .loader_addr    (loader_addr),
    .loader_wdata   (loader_wdata),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata)
  );

  pad_mapper pad_mapper1_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .rx_dir     (pad1_dir),
    .rx_face    (pad1_face),
    .pad_btn    (pad1_btn)
  );

  pad_mapper pad_mapper2_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .rx_dir     (pad2_dir),
    .rx_face    (pad2_face),
    .pad_btn    (pad2_btn)
  );

  // port 0 is player 1, port 1 is player 2
  joypad_shifter joypad_shifter1_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .strobe     (joypad_strobe),
    .pad_clk    (joypad_clk[0]),
    .host_btn   (host_bus.host_btn1),
    .pad_btn    (pad1_btn),
    .serial_out (joypad_data[0])
  );

  joypad_shifter joypad_shifter2_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .strobe     (joypad_strobe),
    .pad_clk    (joypad_clk[1]),
    .host_btn   (host_bus.host_btn2),
    .pad_btn    (pad2_btn),
    .serial_out (joypad_data[1])
  );

endmodule

`default_nettype wire

//--- tb_nes_io_top.sv
// testbench for the console io glue top level
// uart registers, clock-enable slots, memory arbitration, joypad ports, autofire

`timescale 1ns/100ps
`default_nettype none

module tb_nes_io_top;

  localparam int WAIT_LIMIT = 20;  // cycles before a wait gives up
  localparam int AF_HALF    = 16;  // autofire high or low time

  logic                   clk;
  logic                   sys_resetn;
  nes_io_pkg::byte_t      uart_data;
  nes_io_pkg::uart_addr_t uart_addr;
  logic                   uart_write;
  logic                   loader_done, loader_write, loader_refresh;
  nes_io_pkg::mem_addr_t  loader_addr, core_addr;
  nes_io_pkg::byte_t      loader_wdata, core_wdata;
  logic                   cpu_read, ppu_read, core_write;
  logic                   joypad_strobe;
  logic [1:0]             joypad_clk;
  nes_io_pkg::byte_t      pad1_dir, pad1_face, pad2_dir, pad2_face;
  nes_io_pkg::byte_t      loader_byte;
  logic                   loader_byte_valid, loader_reset, run_nes, reset_nes;
  logic                   mem_read_a, mem_read_b, mem_write, mem_refresh;
  nes_io_pkg::mem_addr_t  mem_addr;
  nes_io_pkg::byte_t      mem_wdata;
  logic [1:0]             joypad_data;

  int                checks;
  int                errors;
  int                timeouts;
  int                n;
  nes_io_pkg::byte_t b1, b2, d1, f1, d2, f2, got1, got2;

  nes_io_top nes_io_top_inst (.*);

  always #50 clk = ~clk;

  task automatic note_error(input string msg);
    errors++;
    $display("** Error at time %0t: %s", $time, msg);
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timed out at time %0t waiting for %s", $time, what);
  endtask

  task automatic expect_true(input logic cond, input string msg);
    checks++;
    assert (cond) else note_error(msg);
  endtask

  // console button order from the active-low pad bytes, autofire buttons released
  function automatic nes_io_pkg::nes_btn_t map_pad(input nes_io_pkg::byte_t dir,
                                                   input nes_io_pkg::byte_t face);
    return ~{dir[5], dir[7], dir[6], dir[4], dir[3], dir[0], face[6], face[5]};
  endfunction

  task automatic write_reg(input nes_io_pkg::uart_addr_t addr, input nes_io_pkg::byte_t data);
    @(posedge clk);
    uart_write <= 1'b1;
    uart_addr  <= addr;
    uart_data  <= data;
    @(posedge clk);
    uart_write <= 1'b0;
  endtask

  task automatic strobe_pads();
    @(posedge clk);
    joypad_strobe <= 1'b1;
    @(posedge clk);
    joypad_strobe <= 1'b0;
    @(negedge clk);
  endtask

  // one high-low pulse on the selected pad clocks, shift lands one edge later
  task automatic shift_pads(input logic [1:0] mask);
    @(posedge clk);
    joypad_clk <= mask;
    @(posedge clk);
    joypad_clk <= 2'b00;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic read_ports(output nes_io_pkg::byte_t p1, output nes_io_pkg::byte_t p2);
    strobe_pads();
    for (int k = 0; k < 8; k++) begin
      p1[k] = joypad_data[0];
      p2[k] = joypad_data[1];
      shift_pads(2'b11);
    end
  endtask

  // sampled on the falling edge, away from the drive edge
  assert property (@(negedge clk) reset_nes == !loader_done)
    else note_error("reset_nes is not the inverse of loader_done");
  assert property (@(negedge clk) loader_write |->
                   mem_write && mem_addr == loader_addr && mem_wdata == loader_wdata)
    else note_error("loader write did not take the memory port");

  initial begin
    clk = 1'b0;
    sys_resetn = 1'b0;
    {uart_data, uart_addr, uart_write} = '0;
    {loader_done, loader_write, loader_refresh, loader_addr, loader_wdata} = '0;
    {cpu_read, ppu_read, core_write, core_addr, core_wdata} = '0;
    joypad_strobe = 1'b0;
    joypad_clk = 2'b00;
    {pad1_dir, pad1_face, pad2_dir, pad2_face} = {4{8'hff}};  // pads released
    checks = 0;
    errors = 0;
    timeouts = 0;
    void'($urandom(32'ha7e3));
    repeat (3) @(posedge clk);
    sys_resetn <= 1'b1;
    @(negedge clk);
    expect_true(!loader_reset, "loader_reset still high after reset");

    // rom byte passes through in the write cycle
    b1 = 8'($urandom);
    @(posedge clk);
    uart_write <= 1'b1;
    uart_addr  <= 8'h37;
    uart_data  <= b1;
    @(negedge clk);
    expect_true(loader_byte_valid && loader_byte == b1, "rom byte not forwarded");
    @(posedge clk);
    uart_addr <= 8'h35;  // config bit 0
    uart_data <= 8'h01;
    @(negedge clk);
    expect_true(!loader_byte_valid, "loader strobe on a config write");
    expect_true(!loader_reset, "loader_reset rose before the write edge");
    @(posedge clk);
    uart_write <= 1'b0;
    @(negedge clk);
    expect_true(loader_reset, "loader_reset not set by config bit 0");
    write_reg(8'h35, 8'h00);
    @(negedge clk);
    expect_true(!loader_reset, "loader_reset not cleared by config write");
    write_reg(8'h36, 8'hff);
    write_reg(8'h00, 8'hff);
    strobe_pads();
    expect_true(!loader_reset && joypad_data == 2'b00, "write to unused address took effect");

    // core and memory slots held off until the loader is done
    @(posedge clk);
    cpu_read <= 1'b1;
    ppu_read <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      expect_true(!run_nes && !mem_read_a && !mem_read_b, "slot enabled before loader_done");
    end
    @(posedge clk);
    loader_done <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!mem_read_a && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!mem_read_a)
      note_timeout("first memory slot");
    for (int i = 1; i <= 15; i++) begin
      @(negedge clk);
      expect_true(mem_read_a == (i % 5 == 0), "memory slot not every 5 cycles");
      expect_true(mem_read_b == (i % 5 == 0), "ppu read not in the memory slot");
      expect_true(run_nes == (i % 5 == 4), "run_nes not 4 cycles after the memory slot");
    end

    // idle slot turns into refresh
    @(posedge clk);
    cpu_read <= 1'b0;
    ppu_read <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!mem_refresh && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!mem_refresh)
      note_timeout("idle slot refresh");
    for (int i = 1; i <= 5; i++) begin
      @(negedge clk);
      expect_true(mem_refresh == (i == 5), "refresh outside the idle memory slot");
    end

    // loader write wins over the console in every phase
    @(posedge clk);
    loader_write   <= 1'b1;
    loader_refresh <= 1'b1;
    loader_addr    <= 22'($urandom);
    loader_wdata   <= 8'($urandom);
    core_addr      <= 22'($urandom);
    core_wdata     <= 8'($urandom);
    repeat (5) begin
      @(negedge clk);
      expect_true(mem_write && mem_addr == loader_addr, "loader address not on memory port");
      expect_true(!mem_refresh, "refresh during a loader write");
    end
    @(posedge clk);
    loader_write <= 1'b0;
    repeat (5) begin
      @(negedge clk);
      expect_true(mem_refresh, "loader refresh request ignored");
    end
    @(posedge clk);
    loader_refresh <= 1'b0;

    // host buttons out lsb first, each port on its own clock
    b1 = 8'($urandom);
    b2 = 8'($urandom);
    write_reg(8'h40, b1);
    write_reg(8'h41, b2);
    strobe_pads();
    for (int k = 0; k < 8; k++) begin
      expect_true(joypad_data[0] == b1[k], "player 1 serial bit wrong");
      expect_true(joypad_data[1] == b2[0], "player 2 shifted by player 1 clock");
      shift_pads(2'b01);
    end
    expect_true(joypad_data[0] == 1'b0, "player 1 not empty after eight shifts");
    for (int k = 0; k < 8; k++) begin
      expect_true(joypad_data[1] == b2[k], "player 2 serial bit wrong");
      expect_true(joypad_data[0] == 1'b0, "player 1 shifted by player 2 clock");
      shift_pads(2'b10);
    end
    expect_true(joypad_data[1] == 1'b0, "player 2 not empty after eight shifts");

    // random pad bytes, square and triangle kept released
    repeat (4) begin
      d1 = 8'($urandom);
      f1 = 8'($urandom) | 8'h90;
      d2 = 8'($urandom);
      f2 = 8'($urandom) | 8'h90;
      @(posedge clk);
      pad1_dir  <= d1;
      pad1_face <= f1;
      pad2_dir  <= d2;
      pad2_face <= f2;
      read_ports(got1, got2);
      expect_true(got1 == (map_pad(d1, f1) | b1),
                  $sformatf("player 1 read %h, expected %h", got1, map_pad(d1, f1) | b1));
      expect_true(got2 == (map_pad(d2, f2) | b2),
                  $sformatf("player 2 read %h, expected %h", got2, map_pad(d2, f2) | b2));
    end

    // triangle autofire seen through a latch reloaded every cycle
    write_reg(8'h40, 8'h00);
    @(posedge clk);
    {pad1_dir, pad1_face, pad2_dir, pad2_face} <= {4{8'hff}};
    joypad_strobe <= 1'b1;
    repeat (3) @(negedge clk);
    expect_true(!joypad_data[0], "A pressed with no button held");
    @(posedge clk);
    pad1_face <= 8'hef;
    n = 0;
    @(negedge clk);
    while (!joypad_data[0] && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!joypad_data[0])
      note_timeout("autofire start");
    for (int i = 0; i < 4 * AF_HALF; i++) begin
      expect_true(joypad_data[0] == ((i / AF_HALF) % 2 == 0), "autofire wave off its rhythm");
      @(negedge clk);
    end
    @(posedge clk);
    pad1_face <= 8'hff;
    @(posedge clk);  // latch picks up the released level
    @(negedge clk);
    expect_true(!joypad_data[0], "autofire still firing after release");

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
nes_io_pkg.sv
host_if.sv
uart_reg_decoder.sv
ce_sequencer.sv
mem_arbiter.sv
autofire.sv
pad_mapper.sv
joypad_shifter.sv
nes_io_top.sv
tb_nes_io_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the console io glue testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_nes_io_top -f filelist.f -o tb_nes_io_top

sim_out=$(./obj_dir/tb_nes_io_top)
echo "$sim_out"

grep -qx "Testbench passed" <<< "$sim_out"
